// ==== src/rtx_pkg.sv ====
package rtx_pkg;

  // rendered frame, raster order
  localparam int FRAME_W = 320;
  localparam int FRAME_H = 180;
  localparam int PIX_H_W = 9;  // 0..319
  localparam int PIX_V_W = 8;  // 0..179

  // write slots granted by the frame buffer after reset
  localparam int FB_CREDITS = 4;
  localparam int CREDIT_W   = $clog2(FB_CREDITS + 1);  // must hold FB_CREDITS itself

  // flash protocol: one command byte, then the payload msb first
  localparam int FLASH_PAYLOAD_BYTES = 9;  // 72 bits, one vec3
  localparam int PAYLOAD_CNT_W       = $clog2(FLASH_PAYLOAD_BYTES);
  localparam int FLASH_SHIFT_W       = (FLASH_PAYLOAD_BYTES - 1) * 8;  // all but the last byte

  // fixed point, 12 integer bits over 12 fraction bits
  localparam int FIX_W      = 24;
  localparam int FIX_FRAC_W = 12;

  typedef logic [FIX_W-1:0] fix24_t;

  typedef struct packed {
    fix24_t x;
    fix24_t y;
    fix24_t z;
  } vec3_t;  // 72 bits, x in the top bits

  typedef struct packed {
    vec3_t origin;
    vec3_t forward;
    vec3_t right;
    vec3_t up;
  } camera_t;  // 288 bits

  localparam fix24_t FIX_ZERO  = '0;
  localparam fix24_t FIX_ONE   = fix24_t'(1) << FIX_FRAC_W;
  localparam fix24_t FIX_FOCAL = fix24_t'(FRAME_W / 2) << FIX_FRAC_W;  // 160.0

  // default pose: at the origin looking down +z
  localparam camera_t CAM_DEFAULT = '{
    origin:  '{x: FIX_ZERO, y: FIX_ZERO, z: FIX_ZERO},
    forward: '{x: FIX_ZERO, y: FIX_ZERO, z: FIX_FOCAL},
    right:   '{x: FIX_ONE,  y: FIX_ZERO, z: FIX_ZERO},
    up:      '{x: FIX_ZERO, y: FIX_ONE,  z: FIX_ZERO}
  };

  // low two bits of a command byte
  typedef enum logic [1:0] {
    CAM_ORIGIN  = 2'd0,
    CAM_FORWARD = 2'd1,
    CAM_RIGHT   = 2'd2,
    CAM_UP      = 2'd3
  } flash_target_e;

  typedef enum logic {
    LD_IDLE    = 1'b0,  // waiting for a byte with bit 7 set
    LD_PAYLOAD = 1'b1   // collecting payload bytes
  } loader_state_e;

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // one frame buffer write
  typedef struct packed {
    logic [PIX_H_W-1:0] h;
    logic [PIX_V_W-1:0] v;
    rgb565_t            color;
    logic               overwrite;  // frame-wide, set when the scene changed
  } pix_write_t;

endpackage

// ==== src/uart_camera_loader.sv ====
module uart_camera_loader (
  input  logic                clk_rtx,
  input  logic                sys_rst,
  input  logic                uart_valid,  // one byte per high cycle, no stall
  input  logic [7:0]          uart_byte,
  output rtx_pkg::camera_t    cam,
  output logic                cam_update   // one cycle, right after a vector lands
);

  localparam logic [rtx_pkg::PAYLOAD_CNT_W-1:0] LAST_IDX =
    rtx_pkg::PAYLOAD_CNT_W'(rtx_pkg::FLASH_PAYLOAD_BYTES - 1);

  rtx_pkg::loader_state_e              state;
  logic [rtx_pkg::PAYLOAD_CNT_W-1:0]   byte_cnt;   // payload bytes taken so far
  rtx_pkg::flash_target_e              target;     // from the command byte
  logic [rtx_pkg::FLASH_SHIFT_W-1:0]   shreg;      // first eight payload bytes
  rtx_pkg::vec3_t                      payload_vec;
  logic                                take_cmd;
  logic                                take_data;
  logic                                load_done;

  // byte classification
  assign take_cmd  = uart_valid && (state == rtx_pkg::LD_IDLE) && uart_byte[7];
  assign take_data = uart_valid && (state == rtx_pkg::LD_PAYLOAD);
  assign load_done = take_data && (byte_cnt == LAST_IDX);  // ninth payload byte

  // last byte goes straight in, so the vector is written on the same edge
  assign payload_vec = {shreg, uart_byte};

  // payload path, no reset needed
  always_ff @(posedge clk_rtx) begin
    if (take_cmd) begin
      target <= rtx_pkg::flash_target_e'(uart_byte[1:0]);
    end
    if (take_data) begin
      shreg <= {shreg[rtx_pkg::FLASH_SHIFT_W-9:0], uart_byte};  // msb first
    end
  end

  // fsm and byte counter
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      state    <= rtx_pkg::LD_IDLE;
      byte_cnt <= '0;
    end else begin
      case (state)
        rtx_pkg::LD_IDLE: begin
          if (take_cmd) begin
            state    <= rtx_pkg::LD_PAYLOAD;
            byte_cnt <= '0;
          end  // plain bytes dropped here
        end
        rtx_pkg::LD_PAYLOAD: begin
          if (load_done) begin
            state <= rtx_pkg::LD_IDLE;
          end else if (take_data) begin
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
        default: state <= rtx_pkg::LD_IDLE;
      endcase
    end
  end

  // camera registers, default pose out of reset
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      cam        <= rtx_pkg::CAM_DEFAULT;
      cam_update <= 1'b0;
    end else begin
      cam_update <= load_done;
      if (load_done) begin
        case (target)
          rtx_pkg::CAM_ORIGIN:  cam.origin  <= payload_vec;
          rtx_pkg::CAM_FORWARD: cam.forward <= payload_vec;
          rtx_pkg::CAM_RIGHT:   cam.right   <= payload_vec;
          rtx_pkg::CAM_UP:      cam.up      <= payload_vec;
          default:              cam.origin  <= payload_vec;
        endcase
      end
    end
  end

  // a full command is ten bytes, so two updates can never be back to back
  a_update_single: assert property (
    @(posedge clk_rtx) disable iff (sys_rst)
    cam_update |=> !cam_update
  ) else $error("cam_update high on two consecutive cycles");

endmodule

// ==== src/pixel_tracer.sv ====
module pixel_tracer (
  input  logic                         clk_rtx,
  input  logic                         sys_rst,
  input  rtx_pkg::camera_t             cam,
  input  logic                         issue_ok,   // a frame buffer slot is free
  output logic                         issue,      // pixel started this cycle
  output logic                         pix_valid,  // two cycles after issue
  output logic [rtx_pkg::PIX_H_W-1:0]  pix_h,
  output logic [rtx_pkg::PIX_V_W-1:0]  pix_v,
  output rtx_pkg::rgb565_t             pix_color
);

  localparam logic [rtx_pkg::PIX_H_W-1:0] H_LAST = rtx_pkg::PIX_H_W'(rtx_pkg::FRAME_W - 1);
  localparam logic [rtx_pkg::PIX_V_W-1:0] V_LAST = rtx_pkg::PIX_V_W'(rtx_pkg::FRAME_H - 1);
  localparam int INT_LSB = rtx_pkg::FIX_FRAC_W;  // integer part starts here

  logic                         trace_en;  // low during reset, keeps issue quiet
  logic [rtx_pkg::PIX_H_W-1:0]  h_cnt;
  logic [rtx_pkg::PIX_V_W-1:0]  v_cnt;

  // stage 1
  logic                         s1_valid;
  logic [rtx_pkg::PIX_H_W-1:0]  s1_h;
  logic [rtx_pkg::PIX_V_W-1:0]  s1_v;
  logic [4:0]                   s1_ox;  // only the bits the shader adds
  logic [5:0]                   s1_oy;
  logic [4:0]                   s1_fz;  // forward.z integer bits 7:3

  // start a pixel on every granted cycle
  assign issue = issue_ok && trace_en;

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      trace_en <= 1'b0;
    end else begin
      trace_en <= 1'b1;
    end
  end

  // raster walker, moves only when a pixel starts
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (issue) begin
      if (h_cnt == H_LAST) begin
        h_cnt <= '0;
        v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;  // frame wrap
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // valid bits of the two stages
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      s1_valid  <= 1'b0;
      pix_valid <= 1'b0;
    end else begin
      s1_valid  <= issue;
      pix_valid <= s1_valid;
    end
  end

  // stage 1: coordinates and camera sample
  always_ff @(posedge clk_rtx) begin
    if (issue) begin
      s1_h  <= h_cnt;
      s1_v  <= v_cnt;
      s1_ox <= cam.origin.x[INT_LSB +: 5];
      s1_oy <= cam.origin.y[INT_LSB +: 6];
      s1_fz <= cam.forward.z[INT_LSB + 3 +: 5];
    end
  end

  // stage 2: stand-in shading, sums wrap
  always_ff @(posedge clk_rtx) begin
    if (s1_valid) begin
      pix_h           <= s1_h;
      pix_v           <= s1_v;
      pix_color.red   <= s1_h[7:3] + s1_ox;
      pix_color.green <= s1_v[7:2] + s1_oy;
      pix_color.blue  <= s1_fz ^ s1_h[4:0];  // stripes from the focal length
    end
  end

  // the writer's grant must cover every started pixel
  a_issue_granted: assert property (
    @(posedge clk_rtx) disable iff (sys_rst)
    issue |-> issue_ok
  ) else $error("pixel issued without a free credit");

endmodule

// ==== src/frame_writer.sv ====
module frame_writer (
  input  logic                         clk_rtx,
  input  logic                         sys_rst,
  input  logic                         cam_update,       // camera just changed
  input  logic                         force_overwrite,  // sampled at frame end
  input  logic                         issue,
  input  logic                         pix_valid,
  input  logic [rtx_pkg::PIX_H_W-1:0]  pix_h,
  input  logic [rtx_pkg::PIX_V_W-1:0]  pix_v,
  input  rtx_pkg::rgb565_t             pix_color,
  input  logic                         credit_return,    // one pulse per freed slot
  output logic                         issue_ok,
  output logic                         fb_valid,
  output rtx_pkg::pix_write_t          fb_write
);

  localparam logic [rtx_pkg::PIX_H_W-1:0] H_LAST = rtx_pkg::PIX_H_W'(rtx_pkg::FRAME_W - 1);
  localparam logic [rtx_pkg::PIX_V_W-1:0] V_LAST = rtx_pkg::PIX_V_W'(rtx_pkg::FRAME_H - 1);
  localparam logic [rtx_pkg::CREDIT_W-1:0] CREDITS_FULL =
    rtx_pkg::CREDIT_W'(rtx_pkg::FB_CREDITS);

  logic [rtx_pkg::CREDIT_W-1:0] credits;        // free frame buffer slots
  logic                         overwrite;      // flag of the frame now passing
  logic                         scene_changed;  // camera moved since the last latch
  logic                         last_pix;

  assign issue_ok = (credits != '0);
  assign last_pix = pix_valid && (pix_h == H_LAST) && (pix_v == V_LAST);

  // credit counter
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      credits <= CREDITS_FULL;
    end else begin
      case ({issue, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // both or neither cancel out
      endcase
    end
  end

  // overwrite latch, first frame is a full write
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      overwrite     <= 1'b1;
      scene_changed <= 1'b0;
    end else if (last_pix) begin
      // an update landing on the last pixel still counts for the next frame
      overwrite     <= force_overwrite | scene_changed | cam_update;
      scene_changed <= 1'b0;
    end else if (cam_update) begin
      scene_changed <= 1'b1;
    end
  end

  // write port, one cycle behind the tracer
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      fb_valid <= 1'b0;
    end else begin
      fb_valid <= pix_valid;
    end
  end

  always_ff @(posedge clk_rtx) begin
    if (pix_valid) begin
      fb_write.h         <= pix_h;
      fb_write.v         <= pix_v;
      fb_write.color     <= pix_color;
      fb_write.overwrite <= overwrite;  // old value, even on the last pixel
    end
  end

  a_credit_bound: assert property (
    @(posedge clk_rtx) disable iff (sys_rst)
    credits <= CREDITS_FULL
  ) else $error("credit count above FB_CREDITS");

  // frame buffer returned a slot it never granted
  a_no_spurious_return: assert property (
    @(posedge clk_rtx) disable iff (sys_rst)
    credit_return |-> (credits != CREDITS_FULL)
  ) else $error("credit_return with all credits home");

endmodule

// ==== src/rtx_frontend.sv ====
module rtx_frontend (
  input  logic                 clk_rtx,
  input  logic                 sys_rst,
  input  logic                 uart_valid,       // deserialized uart bytes
  input  logic [7:0]           uart_byte,
  input  logic                 force_overwrite,
  input  logic                 credit_return,    // from the frame buffer
  output logic                 fb_valid,
  output rtx_pkg::pix_write_t  fb_write
);

  rtx_pkg::camera_t             cam;
  logic                         cam_update;
  logic                         issue_ok;
  logic                         issue;
  logic                         pix_valid;
  logic [rtx_pkg::PIX_H_W-1:0]  pix_h;
  logic [rtx_pkg::PIX_V_W-1:0]  pix_v;
  rtx_pkg::rgb565_t             pix_color;

  // camera registers fed by flash commands
  uart_camera_loader i_uart_camera_loader (
    .clk_rtx    (clk_rtx),
    .sys_rst    (sys_rst),
    .uart_valid (uart_valid),
    .uart_byte  (uart_byte),
    .cam        (cam),
    .cam_update (cam_update)
  );

  // stand-in for the rtx engine
  pixel_tracer i_pixel_tracer (
    .clk_rtx   (clk_rtx),
    .sys_rst   (sys_rst),
    .cam       (cam),
    .issue_ok  (issue_ok),
    .issue     (issue),
    .pix_valid (pix_valid),
    .pix_h     (pix_h),
    .pix_v     (pix_v),
    .pix_color (pix_color)
  );

  // credits and overwrite tagging
  frame_writer i_frame_writer (
    .clk_rtx         (clk_rtx),
    .sys_rst         (sys_rst),
    .cam_update      (cam_update),
    .force_overwrite (force_overwrite),
    .issue           (issue),
    .pix_valid       (pix_valid),
    .pix_h           (pix_h),
    .pix_v           (pix_v),
    .pix_color       (pix_color),
    .credit_return   (credit_return),
    .issue_ok        (issue_ok),
    .fb_valid        (fb_valid),
    .fb_write        (fb_write)
  );

endmodule

// ==== tests/tb_rtx_frontend.sv ====
module tb_rtx_frontend;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 2000;  // cycles, for the short waits
  localparam int N_FRAMES   = 4;     // full frames before the run ends

  logic                 clk_rtx = 1'b0;
  logic                 sys_rst;
  logic                 uart_valid;
  logic [7:0]           uart_byte;
  logic                 force_overwrite;
  logic                 credit_return;
  logic                 fb_valid;
  rtx_pkg::pix_write_t  fb_write;

  // frame buffer model
  rtx_pkg::pix_write_t  fb_q[$];    // written, slot not yet freed
  logic [8:0]           uart_q[$];  // {valid, byte}, one entry per cycle
  bit                   withhold;   // frame buffer keeps its slots
  int                   gap_max;    // longest pause between returns
  int                   gap_cnt;
  int                   n_writes;

  // reference model
  rtx_pkg::camera_t     m_cam;
  int                   m_h;
  int                   m_v;
  logic                 m_ovw;        // overwrite of the frame now passing
  logic                 m_scene_chg;  // camera moved since the last frame end
  int                   m_frames;

  rtx_frontend i_rtx_frontend (
    .clk_rtx         (clk_rtx),
    .sys_rst         (sys_rst),
    .uart_valid      (uart_valid),
    .uart_byte       (uart_byte),
    .force_overwrite (force_overwrite),
    .credit_return   (credit_return),
    .fb_valid        (fb_valid),
    .fb_write        (fb_write)
  );

  initial begin
    forever #4 clk_rtx = ~clk_rtx;  // 8 ns period
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_write(input string name, input rtx_pkg::pix_write_t exp,
                             input rtx_pkg::pix_write_t act);
    if (act !== exp) begin
      stop_with_error($sformatf(
        "mismatch %s: expected h=%0d v=%0d rgb=%h ovw=%b, actual h=%0d v=%0d rgb=%h ovw=%b",
        name, exp.h, exp.v, exp.color, exp.overwrite,
        act.h, act.v, act.color, act.overwrite));
    end
  endtask

  task automatic check_credits(input string name, input logic [rtx_pkg::CREDIT_W-1:0] exp,
                               input logic [rtx_pkg::CREDIT_W-1:0] act);
    if (act !== exp) begin
      stop_with_error($sformatf("mismatch %s: expected %0d outstanding, actual %0d",
                                name, exp, act));
    end
  endtask

  // stand-in shading rule, integer parts only
  function automatic rtx_pkg::rgb565_t shade_pixel(input int h, input int v,
                                                   input rtx_pkg::camera_t c);
    logic [8:0]       hb;
    logic [7:0]       vb;
    logic [11:0]      ox;
    logic [11:0]      oy;
    logic [11:0]      fz;
    rtx_pkg::rgb565_t col;
    hb = 9'(h);
    vb = 8'(v);
    ox = c.origin.x[23:12];
    oy = c.origin.y[23:12];
    fz = c.forward.z[23:12];
    col.red   = hb[7:3] + ox[4:0];  // wraps at 5 bits
    col.green = vb[7:2] + oy[5:0];
    col.blue  = fz[7:3] ^ hb[4:0];
    return col;
  endfunction

  // next raster position; frame end latches the next overwrite
  task automatic advance_raster();
    if (m_h == rtx_pkg::FRAME_W - 1 && m_v == rtx_pkg::FRAME_H - 1) begin
      m_ovw            = force_overwrite | m_scene_chg;
      m_scene_chg      = 1'b0;
      m_frames++;
      m_h              = 0;
      m_v              = 0;
      force_overwrite  = 1'($urandom % 2);  // new draw for the next frame end
    end else if (m_h == rtx_pkg::FRAME_W - 1) begin
      m_h = 0;
      m_v++;
    end else begin
      m_h++;
    end
  endtask

  // one cycle: sample at the falling edge, then drive
  task automatic tick();
    rtx_pkg::pix_write_t exp;
    logic [8:0]          ub;
    @(negedge clk_rtx);
    if (fb_valid === 1'b1) begin
      exp.h         = 9'(m_h);
      exp.v         = 8'(m_v);
      exp.color     = shade_pixel(m_h, m_v, m_cam);
      exp.overwrite = m_ovw;
      check_write($sformatf("write %0d", n_writes), exp, fb_write);
      fb_q.push_back(fb_write);
      n_writes++;
      if (fb_q.size() > rtx_pkg::FB_CREDITS) begin
        stop_with_error("more writes outstanding than the frame buffer granted");
      end
      advance_raster();
    end else if (fb_valid !== 1'b0) begin
      stop_with_error("fb_valid is unknown");
    end
    credit_return = 1'b0;
    if (!withhold && fb_q.size() > 0) begin
      if (gap_cnt == 0) begin
        credit_return = 1'b1;  // oldest slot freed
        void'(fb_q.pop_front());
        gap_cnt = $urandom % (gap_max + 1);
      end else begin
        gap_cnt--;
      end
    end
    if (uart_q.size() > 0) begin
      ub         = uart_q.pop_front();
      uart_valid = ub[8];
      uart_byte  = ub[7:0];
    end else begin
      uart_valid = 1'b0;
      uart_byte  = 8'($urandom);  // junk while not valid
    end
  endtask

  task automatic run_writes(input int n);
    int goal;
    int cycles;
    goal   = n_writes + n;
    cycles = 0;
    while (n_writes < goal) begin
      tick();
      cycles++;
      if (cycles > n * (gap_max + 2) + 100) begin
        stop_with_error("timeout, frame buffer writes stopped flowing");
      end
    end
  endtask

  // one flash command with some ignored bytes around it
  task automatic queue_flash_cmd();
    rtx_pkg::flash_target_e tgt;
    rtx_pkg::vec3_t         vec;
    int                     n_noise;
    int                     i;
    tgt = rtx_pkg::flash_target_e'(2'($urandom % 4));
    vec = rtx_pkg::vec3_t'(72'({$urandom, $urandom, $urandom}));
    if (tgt == rtx_pkg::CAM_FORWARD && ($urandom % 2) == 1) begin
      vec.z = m_cam.forward.z;  // colors must not move
    end
    n_noise = $urandom % 4;
    repeat (n_noise) begin
      uart_q.push_back({1'b1, 1'b0, 7'($urandom)});  // bit 7 clear, dropped in idle
      uart_q.push_back({1'b0, 8'($urandom)});
    end
    uart_q.push_back({1'b1, 1'b1, 5'($urandom), tgt});
    for (i = 8; i >= 0; i--) begin
      uart_q.push_back({1'b1, vec[i*8 +: 8]});  // msb first
      if ($urandom % 4 == 0) uart_q.push_back({1'b0, 8'($urandom)});
    end
    case (tgt)
      rtx_pkg::CAM_ORIGIN:  m_cam.origin  = vec;
      rtx_pkg::CAM_FORWARD: m_cam.forward = vec;
      rtx_pkg::CAM_RIGHT:   m_cam.right   = vec;
      default:              m_cam.up      = vec;
    endcase
    m_scene_chg = 1'b1;
  endtask

  // hold credits, drain, load the camera while nothing is in flight
  task automatic stall_and_flash();
    int cycles;
    int quiet;
    int seen;
    int n_cmds;
    withhold = 1'b1;
    cycles   = 0;
    quiet    = 0;
    while (quiet < 16) begin  // writes dry up once every slot is taken
      seen = n_writes;
      tick();
      quiet = (n_writes == seen) ? quiet + 1 : 0;
      cycles++;
      if (cycles > WAIT_LIMIT) stop_with_error("timeout, writes never stopped");
    end
    check_credits("credits exhausted", rtx_pkg::CREDIT_W'(rtx_pkg::FB_CREDITS),
                  rtx_pkg::CREDIT_W'(fb_q.size()));
    n_cmds = 1 + $urandom % 3;
    repeat (n_cmds) queue_flash_cmd();
    cycles = 0;
    while (uart_q.size() > 0) begin
      tick();
      cycles++;
      if (cycles > WAIT_LIMIT) stop_with_error("timeout, uart bytes not sent");
    end
    repeat (2) tick();  // last vector lands, cam_update follows
    withhold = 1'b0;
  endtask

  initial begin
    int i;
    int seg_len;
    void'($urandom(32'hde6c));
    sys_rst         = 1'b1;
    uart_valid      = 1'b0;
    uart_byte       = 8'h00;
    force_overwrite = 1'($urandom % 2);
    credit_return   = 1'b0;
    withhold        = 1'b0;
    gap_max         = 0;
    gap_cnt         = 0;
    n_writes        = 0;
    m_cam           = rtx_pkg::CAM_DEFAULT;
    m_h             = 0;
    m_v             = 0;
    m_ovw           = 1'b1;  // first frame is a full write
    m_scene_chg     = 1'b0;
    m_frames        = 0;
    for (i = 0; i < 10; i++) begin
      @(negedge clk_rtx);
      if (fb_valid !== 1'b0) stop_with_error("fb_valid not low during reset");
    end
    sys_rst = 1'b0;
    run_writes(64);  // default pose, full rate
    while (m_frames < N_FRAMES) begin
      case ($urandom % 3)
        0:       gap_max = 0;
        1:       gap_max = 1;
        default: gap_max = 3;
      endcase
      seg_len = 5000 + $urandom % 25000;
      run_writes(seg_len);
      stall_and_flash();
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
src/rtx_pkg.sv
src/uart_camera_loader.sv
src/pixel_tracer.sv
src/frame_writer.sv
src/rtx_frontend.sv
tests/tb_rtx_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := tb_rtx_frontend
FILELIST  := sources.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
